// File: verilog/i3c_consts.svh
// DAT sizing and SCL timing macros for the I3C command path
`ifndef I3C_CONSTS_SVH
`define I3C_CONSTS_SVH

// Number of entries in the Device Address Table
`define I3C_DAT_DEPTH 32

// Index width that covers every DAT entry
`define I3C_DAT_IDX_W 5

// SCL half-period in core clock cycles
// Kept even so that SDA can move in the middle of the low phase
`define I3C_SCL_HALF 4

`endif

// File: verilog/i3c_pkg.sv
// Command word views, command union and stage-to-stage structs
`include "i3c_consts.svh"
`default_nettype none

package i3c_pkg;

  // Command attribute in the low bits of every command word
  typedef enum logic [2:0] {
    I3C_ATTR_XFER   = 3'd0,
    I3C_ATTR_ASSIGN = 3'd1
  } i3c_cmd_attr_e;

  // Write transfer view
  typedef struct packed {
    logic [15:0]               rsvd;
    logic [7:0]                data;
    logic [`I3C_DAT_IDX_W-1:0] idx;
    i3c_cmd_attr_e             attr;
  } i3c_xfer_cmd_t;

  // Address assign view
  typedef struct packed {
    logic [16:0]               rsvd;
    logic [6:0]                dyn_addr;
    logic [`I3C_DAT_IDX_W-1:0] idx;
    i3c_cmd_attr_e             attr;
  } i3c_assign_cmd_t;

  // One command word, read through the view its attribute selects
  typedef union packed {
    i3c_xfer_cmd_t   xfer;
    i3c_assign_cmd_t assign_cmd;
  } i3c_cmd_u;

  // Stage 1 to stage 2
  typedef struct packed {
    logic                      write;
    logic [`I3C_DAT_IDX_W-1:0] idx;
    logic [6:0]                dyn_addr;
    logic [7:0]                data;
  } i3c_dat_req_t;

  // Stage 2 to stage 3
  typedef struct packed {
    logic [6:0] dyn_addr;
    logic [7:0] data;
  } i3c_frame_t;

endpackage

`default_nettype wire

// File: verilog/i3c_cmd_decoder.sv
// Stage 1 command decoder, turns a host command word into a DAT request
`default_nettype none

module i3c_cmd_decoder import i3c_pkg::*; (
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  i3c_cmd_u     cmd_i,
  input  logic         cmd_valid_i,
  input  logic         busy_i,
  output i3c_dat_req_t dat_req_o,
  output logic         dat_req_valid_o,
  output logic         cmd_err_o
);

  i3c_cmd_attr_e attr;
  i3c_dat_req_t  req_d;
  logic          accept;

  // Strobes seen while a command is in flight are dropped
  assign accept = cmd_valid_i && !busy_i;

  // Attribute sits at the same bits in both views
  assign attr = cmd_i.xfer.attr;

  always_comb begin
    req_d     = '0;
    // Index also shares its bits between the views
    req_d.idx = cmd_i.xfer.idx;
    case (attr)
      I3C_ATTR_ASSIGN: begin
        req_d.write    = 1'b1;
        req_d.dyn_addr = cmd_i.assign_cmd.dyn_addr;
      end
      default: begin
        // Address for a lookup comes from the table
        req_d.data = cmd_i.xfer.data;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dat_req_valid_o <= 1'b0;
      cmd_err_o       <= 1'b0;
    end else begin
      dat_req_valid_o <= 1'b0;
      cmd_err_o       <= 1'b0;
      if (accept) begin
        case (attr)
          I3C_ATTR_XFER, I3C_ATTR_ASSIGN: dat_req_valid_o <= 1'b1;
          default:                        cmd_err_o       <= 1'b1;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dat_req_o <= req_d;
    end
  end

endmodule

`default_nettype wire

// File: verilog/i3c_dat_table.sv
// Stage 2 Device Address Table with write, lookup and invalid entry flag
`include "i3c_consts.svh"
`default_nettype none

module i3c_dat_table import i3c_pkg::*; (
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  i3c_dat_req_t dat_req_i,
  input  logic         dat_req_valid_i,
  output i3c_frame_t   frame_o,
  output logic         frame_valid_o,
  output logic         dat_done_o,
  output logic         dat_err_o
);

  // One valid bit and one dynamic address per entry
  logic [`I3C_DAT_DEPTH-1:0] valid_q;
  logic [6:0]                addr_q [`I3C_DAT_DEPTH];

  logic do_write;
  logic do_lookup;
  logic hit;

  assign do_write  = dat_req_valid_i && dat_req_i.write;
  assign do_lookup = dat_req_valid_i && !dat_req_i.write;
  assign hit       = valid_q[dat_req_i.idx];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q       <= '0;
      frame_valid_o <= 1'b0;
      dat_done_o    <= 1'b0;
      dat_err_o     <= 1'b0;
    end else begin
      frame_valid_o <= do_lookup && hit;
      // Writes finish here, lookups only when the entry is missing
      dat_done_o    <= do_write || (do_lookup && !hit);
      dat_err_o     <= do_lookup && !hit;
      if (do_write) begin
        valid_q[dat_req_i.idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_write) begin
      addr_q[dat_req_i.idx] <= dat_req_i.dyn_addr;
    end
  end

  // Frame payload for the serializer
  always_ff @(posedge clk_i) begin
    if (do_lookup) begin
      frame_o.dyn_addr <= addr_q[dat_req_i.idx];
      frame_o.data     <= dat_req_i.data;
    end
  end

endmodule

`default_nettype wire

// File: verilog/i3c_frame_serializer.sv
// Stage 3 bus frame serializer with SCL generation, SDA shifting and drive mode select
`include "i3c_consts.svh"
`default_nettype none

module i3c_frame_serializer import i3c_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  i3c_frame_t frame_i,
  input  logic       frame_valid_i,
  output logic       scl_o,
  output logic       sda_o,
  output logic       sel_od_pp_o,
  output logic       frame_done_o
);

  // Address, RnW, ACK slot, data byte and T-bit
  localparam int unsigned NumBits    = 18;
  localparam int unsigned FirstPpBit = 9;
  localparam int unsigned PhW        = $clog2(`I3C_SCL_HALF);
  localparam int unsigned MidPh      = `I3C_SCL_HALF / 2;

  typedef enum logic [1:0] {
    S_IDLE,
    S_START,
    S_BITS,
    S_STOP
  } state_e;

  state_e             state_q;
  logic [PhW-1:0]     ph_q;
  logic [4:0]         bit_q;
  logic [NumBits-1:0] sreg_q;
  logic               scl_q;
  logic               sda_q;
  logic               sel_q;
  logic               done_q;
  logic               half_end;
  logic               mid_low;
  logic               t_bit;
  logic               load;
  logic               shift;

  assign half_end = (ph_q == PhW'(`I3C_SCL_HALF - 1));
  // SDA moves only here, well away from both SCL edges
  assign mid_low  = !scl_q && (ph_q == PhW'(MidPh));

  // Odd parity over the data byte
  assign t_bit = ~^frame_i.data;

  assign load  = (state_q == S_IDLE) && frame_valid_i;
  assign shift = (state_q == S_BITS) && half_end && scl_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_IDLE;
      ph_q    <= '0;
      bit_q   <= '0;
      scl_q   <= 1'b1;
      sda_q   <= 1'b1;
      sel_q   <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (state_q != S_IDLE) begin
        ph_q <= half_end ? '0 : ph_q + 1'b1;
      end
      case (state_q)
        S_IDLE: begin
          if (frame_valid_i) begin
            // START, SDA falls while SCL is still high
            sda_q   <= 1'b0;
            ph_q    <= '0;
            bit_q   <= '0;
            state_q <= S_START;
          end
        end
        S_START: begin
          if (half_end) begin
            scl_q   <= 1'b0;
            state_q <= S_BITS;
          end
        end
        S_BITS: begin
          if (mid_low) begin
            sda_q <= sreg_q[NumBits-1];
            // Push-pull from the first data bit on
            sel_q <= (bit_q >= 5'(FirstPpBit));
          end
          if (half_end) begin
            scl_q <= !scl_q;
            // Bit ends on the falling SCL edge
            if (scl_q) begin
              if (bit_q == 5'(NumBits - 1)) begin
                state_q <= S_STOP;
              end else begin
                bit_q <= bit_q + 1'b1;
              end
            end
          end
        end
        S_STOP: begin
          if (mid_low) begin
            sda_q <= 1'b0;
            sel_q <= 1'b0;
          end
          if (half_end) begin
            if (!scl_q) begin
              scl_q <= 1'b1;
            end else begin
              // STOP, SDA rises while SCL is high
              sda_q   <= 1'b1;
              done_q  <= 1'b1;
              state_q <= S_IDLE;
            end
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      sreg_q <= {frame_i.dyn_addr, 1'b0, 1'b1, frame_i.data, t_bit};
    end else if (shift) begin
      sreg_q <= {sreg_q[NumBits-2:0], 1'b0};
    end
  end

  assign scl_o        = scl_q;
  assign sda_o        = sda_q;
  assign sel_od_pp_o  = sel_q;
  assign frame_done_o = done_q;

endmodule

`default_nettype wire

// File: verilog/i3c_ctrl_top.sv
// Top level of the I3C command path with busy tracking and status pulses
`default_nettype none

module i3c_ctrl_top import i3c_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  i3c_cmd_u cmd_i,
  input  logic     cmd_valid_i,
  output logic     scl_o,
  output logic     sda_o,
  output logic     sel_od_pp_o,
  output logic     busy_o,
  output logic     done_o,
  output logic     err_o
);

  i3c_dat_req_t dat_req;
  logic         dat_req_valid;
  i3c_frame_t   frame;
  logic         frame_valid;
  logic         cmd_err;
  logic         dat_done;
  logic         dat_err;
  logic         frame_done;
  logic         busy_q;

  i3c_cmd_decoder u_cmd_decoder (
    .clk_i,
    .arst_n_i,
    .cmd_i,
    .cmd_valid_i,
    .busy_i          (busy_q),
    .dat_req_o       (dat_req),
    .dat_req_valid_o (dat_req_valid),
    .cmd_err_o       (cmd_err)
  );

  i3c_dat_table u_dat_table (
    .clk_i,
    .arst_n_i,
    .dat_req_i       (dat_req),
    .dat_req_valid_i (dat_req_valid),
    .frame_o         (frame),
    .frame_valid_o   (frame_valid),
    .dat_done_o      (dat_done),
    .dat_err_o       (dat_err)
  );

  i3c_frame_serializer u_frame_serializer (
    .clk_i,
    .arst_n_i,
    .frame_i       (frame),
    .frame_valid_i (frame_valid),
    .scl_o,
    .sda_o,
    .sel_od_pp_o,
    .frame_done_o  (frame_done)
  );

  // Only one of the three stages can finish a given command
  assign done_o = cmd_err || dat_done || frame_done;
  assign err_o  = cmd_err || dat_err;

  // Set on an accepted strobe, clear on completion
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
    end else if (done_o) begin
      busy_q <= 1'b0;
    end else if (cmd_valid_i) begin
      busy_q <= 1'b1;
    end
  end

  assign busy_o = busy_q;

endmodule

`default_nettype wire

// File: dv/i3c_ctrl_assertions.sv
// Concurrent checks on the status pulses and drive mode select of the I3C command path
`default_nettype none

module i3c_ctrl_assertions (
  input logic clk_i,
  input logic arst_n_i,
  input logic done_o,
  input logic err_o,
  input logic busy_o,
  input logic sel_od_pp_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Completion is a single-cycle pulse
  done_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    done_o |=> !done_o)
    else $error("done_o stayed high for more than one cycle");

  err_with_done: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    err_o |-> done_o)
    else $error("err_o high without done_o");

  // Push-pull only inside a frame
  pp_while_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    sel_od_pp_o |-> busy_o)
    else $error("sel_od_pp_o high while busy_o is low");

endmodule

bind i3c_ctrl_top i3c_ctrl_assertions u_assertions (
  .clk_i,
  .arst_n_i,
  .done_o,
  .err_o,
  .busy_o,
  .sel_od_pp_o
);

`default_nettype wire

// File: dv/i3c_ctrl_tb.sv
// Testbench for the I3C command path with random commands, DAT model and bus frame monitor
`include "i3c_consts.svh"
`default_nettype none

module i3c_ctrl_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int Timeout = 400;
  localparam int NumCmds = 200;
  localparam int FrameRises = 19;

  logic        clk;
  logic        arst_n;
  logic [31:0] cmd;
  logic        cmd_valid;
  logic        scl;
  logic        sda;
  logic        sel_od_pp;
  logic        busy;
  logic        done;
  logic        err;

  // DAT model
  logic       model_valid [`I3C_DAT_DEPTH];
  logic [6:0] model_addr  [`I3C_DAT_DEPTH];

  // Bus monitor state
  logic scl_prev = 1'b1;
  logic sda_prev = 1'b1;
  logic in_frame = 1'b0;
  logic samp_sda [FrameRises];
  logic samp_sel [FrameRises];
  int   nsamp = 0;
  int   frame_count = 0;
  int   done_count = 0;

  integer seed;
  int     mismatches = 0;
  int     failures = 0;
  int     expected_dones = 0;

  i3c_ctrl_top dut (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .cmd_i       (cmd),
    .cmd_valid_i (cmd_valid),
    .scl_o       (scl),
    .sda_o       (sda),
    .sel_od_pp_o (sel_od_pp),
    .busy_o      (busy),
    .done_o      (done),
    .err_o       (err)
  );

  always #4 clk = ~clk;

  // Bus monitor and done_o counter on the falling clock edge
  always @(negedge clk) begin
    if (arst_n) begin
      if (done === 1'b1) begin
        done_count++;
      end
      if (scl_prev && scl && sda_prev && !sda) begin
        in_frame = 1'b1;
        nsamp = 0;
      end else if (in_frame && !scl_prev && scl) begin
        if (nsamp < FrameRises) begin
          samp_sda[nsamp] = sda;
          samp_sel[nsamp] = sel_od_pp;
        end
        nsamp++;
      end else if (in_frame && scl_prev && scl && !sda_prev && sda) begin
        in_frame = 1'b0;
        frame_count++;
      end
    end
    scl_prev = scl;
    sda_prev = sda;
  end

  // T-bit makes the number of ones over data and T-bit odd
  function automatic logic odd_parity_bit(input logic [7:0] data);
    return ($countones(data) % 2) == 0;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
    mismatches++;
  endtask

  task automatic end_run();
    $display("Closing counts: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (busy !== 1'b0) begin
      @(negedge clk);
      cycles++;
      if (cycles > Timeout) begin
        $display("Timeout at %0t ns: busy_o never went low", $time);
        failures++;
        end_run();
      end
    end
  endtask

  // Strobe one command, optionally a second one while busy, and wait for done_o
  task automatic run_cmd(input logic [31:0] word, input logic [31:0] extra_word,
                         input logic inject, output int latency, output logic got_err);
    int cycles;
    cycles = 0;
    latency = 0;
    got_err = 1'b0;
    @(posedge clk);
    cmd <= word;
    cmd_valid <= 1'b1;
    while (latency == 0) begin
      @(posedge clk);
      if (inject && cycles == 4) begin
        cmd <= extra_word;
        cmd_valid <= 1'b1;
      end else begin
        cmd_valid <= 1'b0;
      end
      @(negedge clk);
      cycles++;
      if (done === 1'b1) begin
        latency = cycles;
        got_err = err;
      end else if (cycles > Timeout) begin
        $display("Timeout at %0t ns: no done_o after a command", $time);
        failures++;
        end_run();
      end
    end
    @(negedge clk);
  endtask

  task automatic check_frame(input logic [6:0] addr, input logic [7:0] data);
    logic [17:0] exp_bits;
    exp_bits = {addr, 1'b0, 1'b1, data, odd_parity_bit(data)};
    if (nsamp != FrameRises) begin
      report_mismatch("scl_o rising edges", nsamp, FrameRises);
    end
    for (int i = 0; i < 18; i++) begin
      if (samp_sda[i] !== exp_bits[17-i]) begin
        report_mismatch($sformatf("sda_o bit %0d", i), samp_sda[i], exp_bits[17-i]);
      end
      // Open-drain through the ACK slot, push-pull afterwards
      if (samp_sel[i] !== (i >= 9)) begin
        report_mismatch($sformatf("sel_od_pp_o bit %0d", i), samp_sel[i], i >= 9);
      end
    end
  endtask

  task automatic send_and_check(input logic [31:0] word, input logic inject,
                                input logic [31:0] extra_word);
    logic [2:0] attr;
    logic [4:0] idx;
    logic       exp_err;
    logic       exp_frame;
    logic       got_err;
    int         exp_lat;
    int         lat;
    int         frames_before;
    attr = word[2:0];
    idx = word[7:3];
    exp_frame = (attr == 3'd0) && model_valid[idx];
    exp_err = (attr > 3'd1) || ((attr == 3'd0) && !model_valid[idx]);
    exp_lat = exp_frame ? 0 : ((attr > 3'd1) ? 1 : 2);
    wait_idle();
    frames_before = frame_count;
    run_cmd(word, extra_word, inject && exp_frame, lat, got_err);
    expected_dones++;
    if (got_err !== exp_err) begin
      report_mismatch("err_o", got_err, exp_err);
    end
    if (exp_lat != 0 && lat != exp_lat) begin
      report_mismatch("done_o latency", lat, exp_lat);
    end
    if (busy !== 1'b0) begin
      report_mismatch("busy_o", busy, 0);
    end
    if (frame_count - frames_before != int'(exp_frame)) begin
      report_mismatch("frame count", frame_count - frames_before, exp_frame);
    end else if (exp_frame) begin
      check_frame(model_addr[idx], word[15:8]);
    end
    if (attr == 3'd1) begin
      model_valid[idx] = 1'b1;
      model_addr[idx] = word[14:8];
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] extra;
    logic [2:0]  attr;
    int unsigned pick;
    seed = 32'h94b2;
    clk = 1'b0;
    arst_n = 1'b0;
    cmd = '0;
    cmd_valid = 1'b0;
    for (int i = 0; i < `I3C_DAT_DEPTH; i++) begin
      model_valid[i] = 1'b0;
      model_addr[i] = '0;
    end
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    if (scl !== 1'b1) begin
      report_mismatch("scl_o", scl, 1);
    end
    if (sda !== 1'b1) begin
      report_mismatch("sda_o", sda, 1);
    end
    if (busy !== 1'b0) begin
      report_mismatch("busy_o", busy, 0);
    end
    if (sel_od_pp !== 1'b0) begin
      report_mismatch("sel_od_pp_o", sel_od_pp, 0);
    end

    // Every entry starts invalid
    for (int i = 0; i < `I3C_DAT_DEPTH; i++) begin
      r = $random(seed);
      send_and_check({r[31:8], 5'(i), 3'd0}, 1'b0, '0);
    end

    for (int n = 0; n < NumCmds; n++) begin
      pick = $unsigned($random(seed)) % 10;
      r = $random(seed);
      extra = $random(seed);
      if (pick == 0) begin
        attr = 3'd2 + 3'($unsigned($random(seed)) % 6);
      end else if (pick < 5) begin
        attr = 3'd1;
      end else begin
        attr = 3'd0;
      end
      // Extra strobe is an address assign that must be dropped
      send_and_check({r[31:3], attr}, r[0] & r[1], {extra[31:3], 3'd1});
    end

    wait_idle();
    repeat (4) @(negedge clk);
    if (done_count != expected_dones) begin
      report_mismatch("done_o pulse count", done_count, expected_dones);
    end
    end_run();
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+verilog
verilog/i3c_pkg.sv
verilog/i3c_cmd_decoder.sv
verilog/i3c_dat_table.sv
verilog/i3c_frame_serializer.sv
verilog/i3c_ctrl_top.sv
dv/i3c_ctrl_assertions.sv
dv/i3c_ctrl_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module i3c_ctrl_tb \
  -o i3c_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/i3c_sim > sim.log 2>&1
tail -n 3 sim.log
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
